//--- line_hash.f
hw/line_pkg.sv
hw/line_ifs.sv
hw/line_gen.sv
hw/line_hash_lane.sv
hw/line_wb_regs.sv
hw/line_hash_top.sv
test/line_hash_chk.sv
test/line_hash_tb.sv

//--- test/line_hash_tb.sv
/*
 * Line hash testbench
 *
 * Drives the Wishbone port of the line hash top level, runs seeded
 * line generation and compares each 64-bit hash read back with a
 * software model of the generator and both hash lanes.
 */

`timescale 1ns/1ps

module line_hash_tb import line_pkg::*;;

    // Longest sequence stays well below this, including all polling
    localparam int MAX_CYCLES = 5000;

    logic clk = 1'b0;
    logic reset_n;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [2:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic wb_ack;

    int cycle_count = 0;
    integer rng_seed = 69;
    logic [63:0] seed;
    logic [63:0] expected;
    logic [31:0] rd;
    logic [COUNT_WIDTH-1:0] count;

    line_hash_top dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #10 clk = ~clk;

    // Run limit that ends any hang in a handshake
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // A failed protocol assertion in the bound checker stops the run
    always @(posedge clk)
    begin
        if (dut.chk.err_count != 0)
        begin
            $display("A protocol assertion in the checker failed");
            $display("*** FAILED ***");
            $fatal(1, "protocol assertion");
        end
    end

    function automatic logic [63:0] rot_left64(input logic [63:0] v, input int r);
        if (r == 0)
            return v;
        return (v << r) | (v >> (64 - r));
    endfunction

    // Software model of the seeded line, the line advance and the bucket folding per lane
    function automatic logic [63:0] model_hash(input logic [63:0] s, input int n);
        logic [255:0] ln;
        logic [31:0] bkt [8];
        logic [31:0] w;
        logic [31:0] lo;
        logic [31:0] hi;
        for (int i = 0; i < 4; i++)
            ln[i*64 +: 64] = LINE_INIT[i*64 +: 64] ^ rot_left64(s, i);
        for (int k = 0; k < n; k++)
        begin
            // Words 0 to 3 belong to the low lane and 4 to 7 to the high lane
            for (int j = 0; j < 8; j++)
            begin
                w = ln[j*32 +: 32];
                if (k == 0)
                    bkt[j] = HASH32_INIT ^ w;
                else
                    bkt[j] = {bkt[j][30:0], bkt[j][31]} ^ w;
            end
            for (int i = 0; i < 4; i++)
                ln[i*64 +: 64] = rot_left64(ln[i*64 +: 64], 8) ^ rot_left64(s, i);
        end
        lo = bkt[0] ^ bkt[1] ^ bkt[2] ^ bkt[3];
        hi = bkt[4] ^ bkt[5] ^ bkt[6] ^ bkt[7];
        return {hi, lo};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // Single classic cycle where the master drops stb once ack is seen
    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        do @(posedge clk); while (!wb_ack);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        do @(posedge clk); while (!wb_ack);
        data = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic start_run(input logic [63:0] s, input logic [COUNT_WIDTH-1:0] n);
        wb_write(REG_SEED_LO, s[31:0]);
        wb_write(REG_SEED_HI, s[63:32]);
        wb_write(REG_COUNT, 32'(n));
        wb_write(REG_CTRL, 32'h1);
    endtask

    // Poll status until the sticky done bit of the current run is set
    task automatic wait_done();
        logic [31:0] st;
        do wb_read(REG_CTRL, st); while (!st[1]);
    endtask

    task automatic read_hash(output logic [63:0] h);
        logic [31:0] lo;
        logic [31:0] hi;
        wb_read(REG_HASH_LO, lo);
        wb_read(REG_HASH_HI, hi);
        h = {hi, lo};
    endtask

    task automatic run_and_check(input logic [63:0] s, input logic [COUNT_WIDTH-1:0] n);
        logic [63:0] h;
        start_run(s, n);
        wait_done();
        read_hash(h);
        check_value("hash", h, model_hash(s, n));
    endtask

    initial
    begin
        logic [63:0] h;
        reset_n  = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        // Idle status and cleared hash after reset
        wb_read(REG_CTRL, rd);
        check_value("status", rd, 0);
        read_hash(h);
        check_value("hash", h, 0);

        // Count is still zero, so start does nothing and status stays clear
        wb_write(REG_CTRL, 32'h1);
        repeat (3)
        begin
            wb_read(REG_CTRL, rd);
            check_value("status", rd, 0);
        end

        // One line checks the seeded line and the first-line bucket rule
        run_and_check(64'h0123_4567_89ab_cdef, 1);

        // Random seeds and counts exercise line advance and both lanes
        for (int n = 0; n < 5; n++)
        begin
            seed  = {$random(rng_seed), $random(rng_seed)};
            count = COUNT_WIDTH'(2 + ($unsigned($random(rng_seed)) % 63));
            run_and_check(seed, count);
        end

        // New seed, count and start written during a run are ignored
        seed = 64'hfeed_face_cafe_beef;
        start_run(seed, 40);
        do wb_read(REG_CTRL, rd); while (!rd[0]);
        start_run(64'h1111_2222_3333_4444, 7);
        wait_done();
        read_hash(h);
        expected = model_hash(seed, 40);
        check_value("hash", h, expected);
        wb_read(REG_COUNT, rd);
        check_value("count", rd, 40);

        // A zero count start keeps busy low, done set and the hash as it was
        wb_write(REG_COUNT, 32'h0);
        wb_write(REG_CTRL, 32'h1);
        repeat (3)
        begin
            wb_read(REG_CTRL, rd);
            check_value("status", rd, 32'h2);
        end
        read_hash(h);
        check_value("hash", h, expected);

        // In back-to-back runs the second one must not carry the first's buckets
        run_and_check(64'h8000_0000_0000_0001, 9);
        run_and_check(64'h0000_0000_0000_0000, 3);

        if (dut.chk.err_count != 0)
        begin
            $display("A protocol assertion in the checker failed");
            $display("*** FAILED ***");
            $fatal(1, "protocol assertion");
        end
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- test/line_hash_chk.sv
/*
 * Line hash protocol checker
 *
 * Concurrent assertions on the Wishbone handshake, the line stream
 * flags and the busy flag after reset. Bound into the top level.
 */

`timescale 1ns/1ps

module line_hash_chk
(
    input  logic clk,
    input  logic reset_n,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_ack,
    input  logic valid,
    input  logic first,
    input  logic last,
    input  logic busy
);

    // Counts failed assertions so the testbench can see them
    int unsigned err_count = 0;

    // The slave answers only inside a cycle the master still holds
    ack_in_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        wb_ack |-> (wb_cyc && wb_stb))
    else
    begin
        $error("wb_ack raised outside a Wishbone cycle");
        err_count++;
    end

    // One ack per request, so it never lasts two cycles
    ack_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        wb_ack |=> !wb_ack)
    else
    begin
        $error("wb_ack held high for two cycles");
        err_count++;
    end

    // first and last mean nothing without valid
    flags_with_valid: assert property (@(posedge clk) disable iff (!reset_n)
        (first || last) |-> valid)
    else
    begin
        $error("first or last seen without valid");
        err_count++;
    end

    // The generator comes out of reset idle
    idle_after_reset: assert property (@(posedge clk)
        !reset_n |=> !busy)
    else
    begin
        $error("busy high in the cycle after reset");
        err_count++;
    end

endmodule

bind line_hash_top line_hash_chk chk (
    .clk     (clk),
    .reset_n (reset_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .valid   (line.valid),
    .first   (line.first),
    .last    (line.last),
    .busy    (ctl.busy)
);

//--- hw/line_hash_top.sv
/*
 * Line hash top level
 *
 * Wishbone register block, seeded line generator and two hash lanes.
 * The generator feeds one stream to both lanes; each lane hashes its
 * own half and reports back to the register block.
 */

`timescale 1ns/1ps

module line_hash_top
(
    input  logic clk,
    input  logic reset_n,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [2:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic wb_ack
);

    // Lane results back to the register block
    logic [31:0] lo_hash;
    logic [31:0] hi_hash;
    logic lo_done;
    logic hi_done;

    line_ctl_if ctl ();
    line_stream_if line ();

    line_wb_regs u_regs (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ctl      (ctl.regs),
        .lo_hash  (lo_hash),
        .hi_hash  (hi_hash),
        .lo_done  (lo_done),
        .hi_done  (hi_done)
    );

    line_gen u_gen (
        .clk     (clk),
        .reset_n (reset_n),
        .ctl     (ctl.gen),
        .line    (line.src)
    );

    // Low half of each line
    line_hash_lane #(.LANE_INDEX(0)) lane_lo (
        .clk     (clk),
        .reset_n (reset_n),
        .line    (line.snk),
        .hash    (lo_hash),
        .done    (lo_done)
    );

    // High half of each line
    line_hash_lane #(.LANE_INDEX(1)) lane_hi (
        .clk     (clk),
        .reset_n (reset_n),
        .line    (line.snk),
        .hash    (hi_hash),
        .done    (hi_done)
    );

endmodule

//--- hw/line_wb_regs.sv
/*
 * Wishbone classic register block
 *
 * Holds seed, line count and the combined 64-bit hash, issues the
 * start pulse to the generator and keeps a sticky done bit. Only
 * single classic cycles are supported; ack follows the request by
 * one cycle and lasts one cycle.
 */

`timescale 1ns/1ps

module line_wb_regs import line_pkg::*;
(
    input  logic clk,
    input  logic reset_n,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [2:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic wb_ack,
    line_ctl_if.regs ctl,
    input  logic [31:0] lo_hash,
    input  logic [31:0] hi_hash,
    input  logic lo_done,
    input  logic hi_done
);

    logic [31:0] seed_lo;
    logic [31:0] seed_hi;
    logic [COUNT_WIDTH-1:0] count_q;
    logic [63:0] hash_q;
    logic done_q;
    logic start_q;
    logic req;
    logic wr_fire;
    logic run_lock;
    logic [31:0] rd_data;

    // A new request is one not yet acknowledged
    assign req = wb_cyc & wb_stb & ~wb_ack;

    // Writes take effect in the ack cycle, while the master still holds them
    assign wr_fire = wb_cyc & wb_stb & wb_we & wb_ack;

    // Seed and count stay frozen from the start pulse to the end of the run
    assign run_lock = ctl.busy | start_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= req;
    end

    // Read mux, status in CTRL and zero for unmapped words
    always_comb
    begin
        rd_data = '0;
        case (wb_adr)
            REG_CTRL:    rd_data = {30'd0, done_q, ctl.busy};
            REG_SEED_LO: rd_data = seed_lo;
            REG_SEED_HI: rd_data = seed_hi;
            REG_COUNT:   rd_data = {{(32 - COUNT_WIDTH){1'b0}}, count_q};
            REG_HASH_LO: rd_data = hash_q[31:0];
            REG_HASH_HI: rd_data = hash_q[63:32];
            default:     rd_data = '0;
        endcase
    end

    // Read data is sampled with the request so it is valid with ack
    always_ff @(posedge clk)
    begin
        if (req)
            wb_dat_r <= rd_data;
    end

    // Configuration writes, ignored while a run is pending or active
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            seed_lo <= '0;
            seed_hi <= '0;
            count_q <= '0;
        end
        else if (wr_fire && !run_lock)
        begin
            case (wb_adr)
                REG_SEED_LO: seed_lo <= wb_dat_w;
                REG_SEED_HI: seed_hi <= wb_dat_w;
                REG_COUNT:   count_q <= wb_dat_w[COUNT_WIDTH-1:0];
                default:     ;
            endcase
        end
    end

    // Start needs an idle generator and a nonzero count
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            start_q <= 1'b0;
        else
            start_q <= wr_fire && (wb_adr == REG_CTRL) && wb_dat_w[0]
                       && !run_lock && (count_q != '0);
    end

    // Both lanes finish on the same edge, their results form one hash
    // Starting a run clears the sticky done bit
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            hash_q <= '0;
            done_q <= 1'b0;
        end
        else if (lo_done && hi_done)
        begin
            hash_q <= {hi_hash, lo_hash};
            done_q <= 1'b1;
        end
        else if (start_q)
        begin
            done_q <= 1'b0;
        end
    end

    assign ctl.start = start_q;
    assign ctl.seed  = {seed_hi, seed_lo};
    assign ctl.count = count_q;

endmodule

//--- hw/line_hash_lane.sv
/*
 * Hash lane over half a line
 *
 * Registers its half of each incoming line, folds it into four 32-bit
 * buckets and reduces the buckets to one 32-bit value in two pipelined
 * XOR stages. done pulses with the final hash of a run.
 */

`timescale 1ns/1ps

module line_hash_lane import line_pkg::*;
#(
    // 0 hashes the low half of the line, 1 the high half
    parameter int LANE_INDEX = 0
)
(
    input  logic clk,
    input  logic reset_n,
    line_stream_if.snk line,
    output logic [31:0] hash,
    output logic done
);

    localparam int N_STAGE0 = LANE_BUCKETS / 2;

    // Input register stage
    logic in_valid;
    logic in_first;
    logic in_last;
    logic [LANE_WIDTH-1:0] in_half;

    // Bucket stage
    logic [LANE_BUCKETS-1:0][31:0] bucket;
    logic bkt_last;

    // Reduction stages
    logic [N_STAGE0-1:0][31:0] stage0;
    logic s0_last;
    logic [31:0] stage1;
    logic s1_last;

    // Input register for the valid, first and last flags of each beat
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            in_valid <= 1'b0;
            in_first <= 1'b0;
            in_last  <= 1'b0;
        end
        else
        begin
            in_valid <= line.valid;
            in_first <= line.valid & line.first;
            in_last  <= line.valid & line.last;
        end
    end

    always_ff @(posedge clk)
    begin
        in_half <= line.data[LANE_INDEX*LANE_WIDTH +: LANE_WIDTH];
    end

    // A first beat restarts every bucket from the init constant
    // Later beats rotate the old bucket one bit left before folding in
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            for (int b = 0; b < LANE_BUCKETS; b++)
            begin
                if (in_first)
                    bucket[b] <= HASH32_INIT ^ in_half[b*32 +: 32];
                else
                    bucket[b] <= {bucket[b][30:0], bucket[b][31]} ^ in_half[b*32 +: 32];
            end
        end
    end

    // First pairwise XOR stage
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < N_STAGE0; i++)
        begin
            stage0[i] <= bucket[2*i] ^ bucket[2*i+1];
        end
    end

    // Second stage folds whatever is left into one word
    always_ff @(posedge clk)
    begin
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < N_STAGE0; i++)
        begin
            acc = acc ^ stage0[i];
        end
        stage1 <= acc;
    end

    // The last flag follows the data through each stage
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            bkt_last <= 1'b0;
            s0_last  <= 1'b0;
            s1_last  <= 1'b0;
        end
        else
        begin
            bkt_last <= in_last;
            s0_last  <= bkt_last;
            s1_last  <= s0_last;
        end
    end

    // Hash is the output of stage 1 and is final while done is high
    assign hash = stage1;
    assign done = s1_last;

endmodule

//--- hw/line_gen.sv
/*
 * Seeded line generator
 *
 * On start it loads a line built from the init pattern and the seed,
 * then emits one line per cycle for the requested count. Each line
 * is derived from the previous one and the seed so that software can
 * rebuild the same sequence.
 */

`timescale 1ns/1ps

module line_gen import line_pkg::*;
(
    input  logic clk,
    input  logic reset_n,
    line_ctl_if.gen ctl,
    line_stream_if.src line
);

    logic beat_valid;
    logic beat_first;
    logic beat_last;
    logic [COUNT_WIDTH-1:0] remain;
    logic [LINE_WIDTH-1:0] line_q;

    // Word i is the init word XOR the seed rotated left by i bits
    function automatic logic [LINE_WIDTH-1:0] seed_line(input logic [63:0] s);
        logic [LINE_WIDTH-1:0] l;
        for (int i = 0; i < LINE_WIDTH / 64; i++)
        begin
            l[i*64 +: 64] = LINE_INIT[i*64 +: 64] ^ rotl64(s, i);
        end
        return l;
    endfunction

    // Each word rotates left by a byte and takes the seed in again
    function automatic logic [LINE_WIDTH-1:0] next_line(input logic [LINE_WIDTH-1:0] l,
                                                        input logic [63:0] s);
        logic [LINE_WIDTH-1:0] n;
        for (int i = 0; i < LINE_WIDTH / 64; i++)
        begin
            n[i*64 +: 64] = {l[i*64 +: 56], l[i*64+56 +: 8]} ^ rotl64(s, i);
        end
        return n;
    endfunction

    // Beat flags; remain counts the beats left including the current one
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            beat_valid <= 1'b0;
            beat_first <= 1'b0;
            beat_last  <= 1'b0;
            remain     <= '0;
        end
        else if (ctl.start)
        begin
            beat_valid <= 1'b1;
            beat_first <= 1'b1;
            beat_last  <= (ctl.count == COUNT_WIDTH'(1));
            remain     <= ctl.count;
        end
        else if (beat_valid)
        begin
            beat_first <= 1'b0;
            remain     <= remain - 1'b1;
            if (remain == COUNT_WIDTH'(1))
            begin
                beat_valid <= 1'b0;
                beat_last  <= 1'b0;
            end
            else
            begin
                beat_last <= (remain == COUNT_WIDTH'(2));
            end
        end
    end

    // The payload is seeded on start and advanced on each beat
    always_ff @(posedge clk)
    begin
        if (ctl.start)
            line_q <= seed_line(ctl.seed);
        else if (beat_valid)
            line_q <= next_line(line_q, ctl.seed);
    end

    assign line.valid = beat_valid;
    assign line.first = beat_first;
    assign line.last  = beat_last;
    assign line.data  = line_q;

    // Busy covers exactly the beats of a run
    assign ctl.busy = beat_valid;

endmodule

//--- hw/line_ifs.sv
/*
 * Line hash interfaces
 *
 * line_ctl_if carries the run request from the register block to the
 * generator and the busy flag back. line_stream_if carries one line
 * per cycle from the generator to both hash lanes.
 */

`timescale 1ns/1ps

interface line_ctl_if import line_pkg::*; ();

    // One-cycle pulse that begins a run
    logic start;

    // Held stable by the register block while busy is high
    logic [63:0] seed;
    logic [COUNT_WIDTH-1:0] count;

    // High while the generator emits lines
    logic busy;

    modport regs (
        output start, seed, count,
        input  busy
    );

    modport gen (
        input  start, seed, count,
        output busy
    );

endinterface

interface line_stream_if import line_pkg::*; ();

    // No ready signal, a sink takes every beat
    logic valid;
    logic first;
    logic last;
    logic [LINE_WIDTH-1:0] data;

    modport src (
        output valid, first, last, data
    );

    modport snk (
        input  valid, first, last, data
    );

endinterface

//--- hw/line_pkg.sv
/*
 * Line hash shared definitions
 *
 * Line and lane geometry, the fixed init pattern of the generator,
 * the bucket start value and the Wishbone register map. Also holds
 * the 64-bit rotate used to derive each line from the seed.
 */

package line_pkg;

    // Full line carried on the stream, split into two equal lanes
    localparam int LINE_WIDTH = 256;
    localparam int LANE_WIDTH = LINE_WIDTH / 2;

    // Each lane folds its half into this many 32-bit buckets
    localparam int LANE_BUCKETS = LANE_WIDTH / 32;

    // Four 64-bit init words, word 0 in the low bits
    localparam logic [LINE_WIDTH-1:0] LINE_INIT = {
        64'h33b23fb3ab3c4277,
        64'h8519a51b2767a2fa,
        64'h54de0dc97b564cbf,
        64'h860761722b164a00
    };

    // Every bucket restarts from this value on the first line of a run
    localparam logic [31:0] HASH32_INIT = 32'h9e3779b9;

    // Line count register width, so a run holds up to 65535 lines
    localparam int COUNT_WIDTH = 16;

    // Word addresses of the register port
    localparam logic [2:0] REG_CTRL    = 3'd0;
    localparam logic [2:0] REG_SEED_LO = 3'd1;
    localparam logic [2:0] REG_SEED_HI = 3'd2;
    localparam logic [2:0] REG_COUNT   = 3'd3;
    localparam logic [2:0] REG_HASH_LO = 3'd4;
    localparam logic [2:0] REG_HASH_HI = 3'd5;

    // Rotate a 64-bit word left by r bits
    function automatic logic [63:0] rotl64(input logic [63:0] v, input int unsigned r);
        logic [127:0] t;
        t = {v, v} << (r % 64);
        return t[127:64];
    endfunction

endpackage
